//--- include/fetch_mem_defines.svh
`ifndef FETCH_MEM_DEFINES_SVH
`define FETCH_MEM_DEFINES_SVH

// address width, only bits 15..3 reach the cache index and tag
`define XLEN 32

`define CACHE_LINES 32
`define CACHE_LINE_BITS $clog2(`CACHE_LINES)

`define MEM_WORDS 256 // doublewords, address bits 10..3

// acceptance to data return, keep below 15 so live tags stay unique
`define MEM_LATENCY 6

`endif

//--- design/mem_bus_pkg.sv
package mem_bus_pkg;

    // bus opcode
    typedef enum logic [1:0] {
        bus_none  = 2'h0,
        bus_load  = 2'h1,
        bus_store = 2'h2
    } bus_command_e;

    // transaction tag, zero means no transaction
    typedef logic [3:0] mem_tag_t;

    typedef logic [63:0] dword_t;

endpackage

//--- design/cache_pkg.sv
`include "fetch_mem_defines.svh"

package cache_pkg;

    // line index, address bits 7..3
    typedef logic [`CACHE_LINE_BITS-1:0] cache_index_t;

    // line tag, the rest of bits 15..3 above the index
    typedef logic [12-`CACHE_LINE_BITS:0] cache_tag_t;

    // data port FSM
    typedef enum logic [1:0] {
        port_idle    = 2'h0,
        port_request = 2'h1,
        port_wait    = 2'h2
    } dport_state_e;

endpackage

//--- design/icache.sv
`timescale 1ns/1ps
`include "fetch_mem_defines.svh"

module icache (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       squash,
    input  logic [`XLEN-1:0]           fetch_addr,
    output mem_bus_pkg::dword_t        fetch_data,
    output logic                       fetch_valid,
    output mem_bus_pkg::bus_command_e  icache_command,
    output logic [`XLEN-1:0]           icache_addr,
    input  mem_bus_pkg::mem_tag_t      icache_response,
    input  mem_bus_pkg::dword_t        mem_data,
    input  mem_bus_pkg::mem_tag_t      mem_tag
);
    import mem_bus_pkg::*;
    import cache_pkg::*;

    cache_index_t current_index;
    cache_tag_t   current_tag;
    cache_index_t last_index;
    cache_tag_t   last_tag;
    logic         last_valid;       // last_index/last_tag hold a real address

    mem_tag_t     pending_tag;      // tag of the accepted miss, zero if none
    logic         miss_outstanding; // miss not yet accepted by memory

    logic         changed_addr;
    logic         tag_match;
    logic         line_fill;
    logic         unanswered_miss;

    // line storage
    dword_t                  line_data [`CACHE_LINES];
    cache_tag_t              line_tag  [`CACHE_LINES];
    logic [`CACHE_LINES-1:0] line_valid;

    assign {current_tag, current_index} = fetch_addr[15:3];

    // a new fetch address starts a fresh lookup
    assign changed_addr = !last_valid
                       || (current_index != last_index)
                       || (current_tag != last_tag);

    assign tag_match = (pending_tag != '0) && (mem_tag == pending_tag);

    // the return only fills if the address that missed is still presented
    assign line_fill = tag_match && !changed_addr && !squash;

    assign unanswered_miss = changed_addr ? !fetch_valid
                                          : miss_outstanding && (icache_response == '0);

    // retried every cycle until the arbiter hands back a tag
    assign icache_command = (miss_outstanding && !changed_addr) ? bus_load : bus_none;
    assign icache_addr    = {fetch_addr[`XLEN-1:3], 3'b000}; // doubleword aligned

    // hit path, purely combinational
    assign fetch_data  = line_valid[current_index] ? line_data[current_index] : '0;
    assign fetch_valid = line_valid[current_index]
                      && (line_tag[current_index] == current_tag);

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            last_valid       <= 1'b0; // forces a fresh lookup next cycle
            pending_tag      <= '0;
            miss_outstanding <= 1'b0;
        end else begin
            last_valid       <= 1'b1;
            last_index       <= current_index;
            last_tag         <= current_tag;
            miss_outstanding <= unanswered_miss;

            if (miss_outstanding) begin
                pending_tag <= icache_response; // stays zero while rejected
            end else if (changed_addr || tag_match) begin
                pending_tag <= '0;              // dropped on move or consumed by fill
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;
        end else if (line_fill) begin
            line_valid[current_index] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (line_fill) begin
            line_data[current_index] <= mem_data;
            line_tag[current_index]  <= current_tag;
        end
    end

    // a fill with the address held becomes a hit on the next cycle
    fill_then_hit: assert property (@(posedge clock) disable iff (reset)
        line_fill |=> fetch_valid || changed_addr);

    // once hit, the line stays resident while the address is held
    hit_is_sticky: assert property (@(posedge clock) disable iff (reset)
        fetch_valid |=> fetch_valid || changed_addr);

endmodule

//--- design/data_port.sv
`timescale 1ns/1ps
`include "fetch_mem_defines.svh"

module data_port (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       req_valid,
    input  logic                       req_store,
    output logic                       req_ready,
    input  logic [`XLEN-1:0]           req_addr,
    input  mem_bus_pkg::dword_t        req_data,
    output logic                       resp_valid,
    output mem_bus_pkg::dword_t        resp_data,
    output mem_bus_pkg::bus_command_e  dport_command,
    output logic [`XLEN-1:0]           dport_addr,
    output mem_bus_pkg::dword_t        dport_data,
    input  mem_bus_pkg::mem_tag_t      dport_response,
    input  mem_bus_pkg::dword_t        mem_data,
    input  mem_bus_pkg::mem_tag_t      mem_tag
);
    import mem_bus_pkg::*;
    import cache_pkg::*;

    dport_state_e     state;
    dport_state_e     next_state;

    // captured request
    logic             hold_store;
    logic [`XLEN-1:0] hold_addr;
    dword_t           hold_data;
    mem_tag_t         pending_tag;

    logic             accepted;
    logic             store_done;
    logic             load_done;

    assign req_ready = (state == port_idle);

    assign accepted   = (state == port_request) && (dport_response != '0);
    assign store_done = accepted && hold_store;           // stores finish at acceptance
    assign load_done  = (state == port_wait) && (mem_tag == pending_tag);

    assign resp_valid = store_done || load_done;
    assign resp_data  = load_done ? mem_data : hold_data; // store echoes its data

    assign dport_command = (state != port_request) ? bus_none
                         : hold_store              ? bus_store
                         :                           bus_load;
    assign dport_addr    = {hold_addr[`XLEN-1:3], 3'b000};
    assign dport_data    = hold_data;

    always_comb begin
        next_state = state;
        case (state)
            port_idle: begin
                if (req_valid) begin
                    next_state = port_request;
                end
            end
            port_request: begin
                if (accepted) begin
                    next_state = hold_store ? port_idle : port_wait;
                end
            end
            port_wait: begin
                if (load_done) begin
                    next_state = port_idle;
                end
            end
            default: next_state = port_idle;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= port_idle;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clock) begin
        if (req_valid && req_ready) begin
            hold_store <= req_store;
            hold_addr  <= req_addr;
            hold_data  <= req_data;
        end
        if (accepted) begin
            pending_tag <= dport_response; // nonzero by definition of accepted
        end
    end

    // an accepted load answers exactly MEM_LATENCY cycles later
    load_latency: assert property (@(posedge clock) disable iff (reset)
        accepted && !hold_store |-> ##`MEM_LATENCY load_done);

endmodule

//--- design/mem_arbiter.sv
`timescale 1ns/1ps
`include "fetch_mem_defines.svh"

module mem_arbiter (
    input  logic                       clock,
    input  mem_bus_pkg::bus_command_e  dport_command,
    input  logic [`XLEN-1:0]           dport_addr,
    input  mem_bus_pkg::dword_t        dport_data,
    output mem_bus_pkg::mem_tag_t      dport_response,
    input  mem_bus_pkg::bus_command_e  icache_command,
    input  logic [`XLEN-1:0]           icache_addr,
    output mem_bus_pkg::mem_tag_t      icache_response,
    output mem_bus_pkg::bus_command_e  mem_command,
    output logic [`XLEN-1:0]           mem_addr,
    output mem_bus_pkg::dword_t        mem_wdata,
    input  mem_bus_pkg::mem_tag_t      mem_response
);
    import mem_bus_pkg::*;

    logic dport_grant; // data port wins whenever it asks

    assign dport_grant = (dport_command != bus_none);

    assign mem_command = dport_grant ? dport_command : icache_command;
    assign mem_addr    = dport_grant ? dport_addr : icache_addr;
    assign mem_wdata   = dport_data; // icache never stores

    // tag only goes back to the winner, loser sees zero and retries
    assign dport_response  = dport_grant ? mem_response : '0;
    assign icache_response = dport_grant ? '0 : mem_response;

    // memory must take every command in the cycle it appears
    same_cycle_accept: assert property (@(posedge clock)
        (mem_command != bus_none) |-> (mem_response != '0));

    // an idle icache never gets a tag handed back
    tag_needs_command: assert property (@(posedge clock)
        (icache_response != '0) |-> (icache_command != bus_none));

endmodule

//--- design/mem_controller.sv
`timescale 1ns/1ps
`include "fetch_mem_defines.svh"

module mem_controller (
    input  logic                       clock,
    input  logic                       reset,
    input  mem_bus_pkg::bus_command_e  mem_command,
    input  logic [`XLEN-1:0]           mem_addr,
    input  mem_bus_pkg::dword_t        mem_wdata,
    output mem_bus_pkg::mem_tag_t      mem_response,
    output mem_bus_pkg::dword_t        mem_data,
    output mem_bus_pkg::mem_tag_t      mem_tag
);
    import mem_bus_pkg::*;

    localparam int word_bits = $clog2(`MEM_WORDS);

    dword_t               memory [`MEM_WORDS];
    mem_tag_t             next_tag;                 // tag handed to the next accepted command
    mem_tag_t             pipe_tag  [`MEM_LATENCY];
    dword_t               pipe_data [`MEM_LATENCY];
    logic [word_bits-1:0] word_index;
    logic                 accept;
    logic                 load_accept;

    assign word_index  = mem_addr[word_bits+2:3]; // bits 10..3
    assign accept      = (mem_command != bus_none);
    assign load_accept = (mem_command == bus_load);

    // every command is taken in the cycle it appears
    assign mem_response = accept ? next_tag : '0;

    assign mem_tag  = pipe_tag[`MEM_LATENCY-1];
    assign mem_data = pipe_data[`MEM_LATENCY-1];

    // counts 1..15, never zero
    always_ff @(posedge clock) begin
        if (reset) begin
            next_tag <= 4'd1;
        end else if (accept) begin
            next_tag <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `MEM_WORDS; i++) begin
                memory[i] <= '0;
            end
        end else if (mem_command == bus_store) begin
            memory[word_index] <= mem_wdata; // store completes here
        end
    end

    // tag pipeline, zero marks an empty slot
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `MEM_LATENCY; i++) begin
                pipe_tag[i] <= '0;
            end
        end else begin
            pipe_tag[0] <= load_accept ? next_tag : '0;
            for (int i = 1; i < `MEM_LATENCY; i++) begin
                pipe_tag[i] <= pipe_tag[i-1];
            end
        end
    end

    // data travels beside its tag
    always_ff @(posedge clock) begin
        pipe_data[0] <= memory[word_index]; // read at acceptance
        for (int i = 1; i < `MEM_LATENCY; i++) begin
            pipe_data[i] <= pipe_data[i-1];
        end
    end

    // the tag given at acceptance is the one broadcast with the data
    return_tag: assert property (@(posedge clock) disable iff (reset)
        load_accept |-> ##`MEM_LATENCY
            (mem_tag != '0) && (mem_tag == $past(mem_response, `MEM_LATENCY)));

endmodule

//--- design/fetch_mem_top.sv
`timescale 1ns/1ps
`include "fetch_mem_defines.svh"

module fetch_mem_top (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 squash,
    input  logic [`XLEN-1:0]     fetch_addr,
    output mem_bus_pkg::dword_t  fetch_data,
    output logic                 fetch_valid,
    input  logic                 req_valid,
    input  logic                 req_store,
    output logic                 req_ready,
    input  logic [`XLEN-1:0]     req_addr,
    input  mem_bus_pkg::dword_t  req_data,
    output logic                 resp_valid,
    output mem_bus_pkg::dword_t  resp_data
);
    import mem_bus_pkg::*;

    // data port side
    bus_command_e     dport_command;
    logic [`XLEN-1:0] dport_addr;
    dword_t           dport_data;
    mem_tag_t         dport_response;

    // icache side
    bus_command_e     icache_command;
    logic [`XLEN-1:0] icache_addr;
    mem_tag_t         icache_response;

    // shared memory bus and broadcast return
    bus_command_e     mem_command;
    logic [`XLEN-1:0] mem_addr;
    dword_t           mem_wdata;
    mem_tag_t         mem_response;
    dword_t           mem_data;
    mem_tag_t         mem_tag;

    icache icache_i (
        .clock           (clock),
        .reset           (reset),
        .squash          (squash),
        .fetch_addr      (fetch_addr),
        .fetch_data      (fetch_data),
        .fetch_valid     (fetch_valid),
        .icache_command  (icache_command),
        .icache_addr     (icache_addr),
        .icache_response (icache_response),
        .mem_data        (mem_data),
        .mem_tag         (mem_tag)
    );

    data_port data_port_i (
        .clock          (clock),
        .reset          (reset),
        .req_valid      (req_valid),
        .req_store      (req_store),
        .req_ready      (req_ready),
        .req_addr       (req_addr),
        .req_data       (req_data),
        .resp_valid     (resp_valid),
        .resp_data      (resp_data),
        .dport_command  (dport_command),
        .dport_addr     (dport_addr),
        .dport_data     (dport_data),
        .dport_response (dport_response),
        .mem_data       (mem_data),
        .mem_tag        (mem_tag)
    );

    mem_arbiter mem_arbiter_i (
        .clock           (clock),
        .dport_command   (dport_command),
        .dport_addr      (dport_addr),
        .dport_data      (dport_data),
        .dport_response  (dport_response),
        .icache_command  (icache_command),
        .icache_addr     (icache_addr),
        .icache_response (icache_response),
        .mem_command     (mem_command),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata),
        .mem_response    (mem_response)
    );

    mem_controller mem_controller_i (
        .clock        (clock),
        .reset        (reset),
        .mem_command  (mem_command),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_response (mem_response),
        .mem_data     (mem_data),
        .mem_tag      (mem_tag)
    );

endmodule

//--- bench/fetch_mem_checker.sv
`timescale 1ns/1ps
`include "fetch_mem_defines.svh"

module fetch_mem_checker (
    input  logic                 clock,
    input  logic                 reset,
    input  logic [`XLEN-1:0]     fetch_addr,
    input  mem_bus_pkg::dword_t  fetch_data,
    input  logic                 fetch_valid,
    input  logic                 req_valid,
    input  logic                 req_store,
    input  logic                 req_ready,
    input  logic [`XLEN-1:0]     req_addr,
    input  mem_bus_pkg::dword_t  req_data,
    input  logic                 resp_valid,
    input  mem_bus_pkg::dword_t  resp_data,
    output int                   error_count,
    output int                   fetch_checks,
    output int                   load_checks
);
    import mem_bus_pkg::*;

    dword_t     shadow [`MEM_WORDS]; // expected memory contents
    logic       open_store;          // request taken by the data port
    logic [7:0] open_word;
    dword_t     open_data;
    int         errors = 0;
    int         fetches = 0;
    int         loads = 0;

    assign error_count  = errors;
    assign fetch_checks = fetches;
    assign load_checks  = loads;

    task automatic compare(string name, dword_t expected, dword_t actual);
        if (actual !== expected) begin
            $display("** Error at %0t: %s expected %h, got %h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    always @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `MEM_WORDS; i++) begin
                shadow[i] = '0; // memory clears on reset too
            end
            open_store = 1'b0;
        end else begin
            if (fetch_valid) begin
                compare("fetch_data", shadow[fetch_addr[10:3]], fetch_data);
                fetches++;
            end
            if (resp_valid && open_store) begin
                compare("resp_data", open_data, resp_data); // store echo
                shadow[open_word] = open_data;
            end else if (resp_valid) begin
                compare("resp_data", shadow[open_word], resp_data);
                loads++;
            end
            if (req_valid && req_ready) begin
                open_store = req_store;
                open_word  = req_addr[10:3];
                open_data  = req_data;
            end
        end
    end

endmodule

//--- bench/fetch_mem_tb.sv
`timescale 1ns/1ps
`include "fetch_mem_defines.svh"

module fetch_mem_tb;
    import mem_bus_pkg::*;

    localparam int wait_limit = 200; // cycles allowed per wait

    logic             clock;
    logic             reset;
    logic             squash;
    logic [`XLEN-1:0] fetch_addr;
    dword_t           fetch_data;
    logic             fetch_valid;
    logic             req_valid;
    logic             req_store;
    logic             req_ready;
    logic [`XLEN-1:0] req_addr;
    dword_t           req_data;
    logic             resp_valid;
    dword_t           resp_data;
    int               error_count;
    int               fetch_checks;
    int               load_checks;
    int               local_errors = 0; // bench checks and timeouts
    int               reported = 0;
    int unsigned      seed = 32'hb801;
    int               idx;

    fetch_mem_top fetch_mem_top_i (.*);
    fetch_mem_checker checker_i (.*);

    function automatic logic [`XLEN-1:0] word_addr(int word);
        return word * 8;
    endfunction

    task automatic check_value(string name, dword_t expected, dword_t actual);
        if (actual !== expected) begin
            $display("** Error at %0t: %s expected %h, got %h",
                     $time, name, expected, actual);
            local_errors++;
        end
    endtask

    task automatic hold_reset();
        reset = 1'b1;
        repeat (4) @(negedge clock);
        reset = 1'b0;
    endtask

    task automatic present(logic [`XLEN-1:0] addr);
        @(negedge clock);
        fetch_addr = addr;
        #10; // let the hit path settle
    endtask

    task automatic wait_fetch();
        int n;
        n = 0;
        while (!fetch_valid && n < wait_limit) begin
            @(negedge clock);
            n++;
        end
        if (!fetch_valid) begin
            $display("fetch of address %h timed out without fetch_valid", fetch_addr);
            local_errors++;
        end
    endtask

    task automatic fetch_word(logic [`XLEN-1:0] addr);
        present(addr);
        wait_fetch();
    endtask

    task automatic send_request(logic store, int word, dword_t data);
        int n;
        n = 0;
        @(negedge clock);
        while (!req_ready && n < wait_limit) begin
            @(negedge clock);
            n++;
        end
        if (!req_ready) begin
            $display("data port stayed busy, request to word %0d never sent", word);
            local_errors++;
        end else begin
            req_valid = 1'b1;
            req_store = store;
            req_addr  = word_addr(word);
            req_data  = data;
            @(negedge clock);
            req_valid = 1'b0;
            n = 0;
            while (!resp_valid && n < wait_limit) begin
                @(negedge clock);
                n++;
            end
            if (!resp_valid) begin
                $display("request to word %0d timed out without resp_valid", word);
                local_errors++;
            end
        end
    endtask

    task automatic report_test(int number, string name);
        int errors;
        @(negedge clock); // checker samples the last response first
        errors   = error_count + local_errors - reported;
        reported = error_count + local_errors;
        $display("test %0d %s: %0d errors", number, name, errors);
    endtask

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    initial begin
        void'($urandom(seed));
        squash     = 1'b1; // no fills while code words are written
        fetch_addr = '0;
        req_valid  = 1'b0;
        req_store  = 1'b0;
        req_addr   = '0;
        req_data   = '0;
        hold_reset();

        for (int w = 0; w < `MEM_WORDS; w++) begin
            send_request(1'b1, w, {$urandom, $urandom});
        end
        repeat (20) send_request(1'b0, $urandom % `MEM_WORDS, '0);
        report_test(1, "fill");

        squash = 1'b0;
        repeat (10) begin
            idx = $urandom % 128;
            fetch_word(word_addr(idx));
            present(word_addr(idx) ^ 32'h100); // other tag, one cycle only
            present(word_addr(idx));
            check_value("fetch_valid", 1, fetch_valid);
        end
        report_test(2, "miss then hit");

        idx = $urandom % 32 + 32 * ($urandom % 3);
        repeat (2) begin
            fetch_word(word_addr(idx));
            fetch_word(word_addr(idx + 32)); // same index, next tag
        end
        report_test(3, "eviction");

        fork
            repeat (30) fetch_word(word_addr($urandom % 128));
            repeat (30) send_request(($urandom % 2) == 1, 128 + $urandom % 128,
                                     {$urandom, $urandom});
        join
        report_test(4, "concurrent traffic");

        idx = $urandom % 32;
        fetch_word(word_addr(idx));
        present(word_addr(idx + 32));
        repeat (3) @(negedge clock); // miss now in flight
        squash     = 1'b1;
        fetch_addr = word_addr(idx + 64);
        @(negedge clock);
        squash = 1'b0;
        #10;
        check_value("fetch_valid", 0, fetch_valid);
        wait_fetch();
        report_test(5, "squash");

        @(negedge clock);
        req_valid = 1'b1; // load still busy when reset hits
        req_store = 1'b0;
        req_addr  = word_addr(200);
        @(negedge clock);
        req_valid = 1'b0;
        hold_reset();
        #10;
        check_value("req_ready", 1, req_ready);
        check_value("fetch_valid", 0, fetch_valid);
        wait_fetch();
        check_value("fetch_data", 0, fetch_data);
        report_test(6, "reset state");

        $display("%0d fetch checks, %0d load checks, %0d errors",
                 fetch_checks, load_checks, reported);
        if (reported == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- fetch_mem.f
+incdir+include
design/mem_bus_pkg.sv
design/cache_pkg.sv
design/icache.sv
design/data_port.sv
design/mem_arbiter.sv
design/mem_controller.sv
design/fetch_mem_top.sv
bench/fetch_mem_checker.sv
bench/fetch_mem_tb.sv

//--- Bender.yml
package:
  name: fetch_mem

sources:
  - include_dirs:
      - include
    files:
      - design/mem_bus_pkg.sv
      - design/cache_pkg.sv
      - design/icache.sv
      - design/data_port.sv
      - design/mem_arbiter.sv
      - design/mem_controller.sv
      - design/fetch_mem_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/fetch_mem_checker.sv
      - bench/fetch_mem_tb.sv
